/* design/new_usb_ohci.sv */
module new_usb_ohci import new_usb_ohci_pkg::*; #(
  parameter int unsigned NumPorts       = NumPhyPorts,
  parameter int unsigned DebounceCycles = 8
) (
  input  logic                soc_clk_i,
  input  logic                arst_n_i,
  // Control subordinate port
  input  reg_req_t            ctrl_req_i,
  output reg_rsp_t            ctrl_rsp_o,
  output logic                intr_o,
  // Line state per root-hub port
  input  logic [NumPorts-1:0] phy_dp_i,
  input  logic [NumPorts-1:0] phy_dm_i
);

  reg_wr_t                      reg_wr;
  reg_rd_t                      reg_rd;
  logic          [31:0]         control;
  logic          [31:0]         fm_interval;
  logic          [31:0]         fm_remaining;
  logic          [31:0]         fm_number;
  logic          [31:0]         int_status;
  logic          [31:0]         int_enable;
  logic                         sof;
  logic                         rhsc;
  rh_port_word_u [NumPorts-1:0] port_words;

  // Strobe into write command and read selection
  new_usb_ohci_reg_decode #(
    .NumPorts ( NumPorts )
  ) i_reg_decode (
    .req_i ( ctrl_req_i ),
    .wr_o  ( reg_wr ),
    .rd_o  ( reg_rd )
  );

  new_usb_ohci_frame_timer i_frame_timer (
    .soc_clk_i      ( soc_clk_i ),
    .arst_n_i       ( arst_n_i ),
    .wr_i           ( reg_wr ),
    .hcfs_o         ( ),              // State also visible through HcControl
    .control_o      ( control ),
    .fm_interval_o  ( fm_interval ),
    .fm_remaining_o ( fm_remaining ),
    .fm_number_o    ( fm_number ),
    .sof_o          ( sof )
  );

  new_usb_ohci_root_hub #(
    .NumPorts       ( NumPorts ),
    .DebounceCycles ( DebounceCycles )
  ) i_root_hub (
    .soc_clk_i ( soc_clk_i ),
    .arst_n_i  ( arst_n_i ),
    .wr_i      ( reg_wr ),
    .phy_dp_i  ( phy_dp_i ),
    .phy_dm_i  ( phy_dm_i ),
    .port_o    ( port_words ),
    .rhsc_o    ( rhsc )
  );

  new_usb_ohci_intr i_intr (
    .soc_clk_i ( soc_clk_i ),
    .arst_n_i  ( arst_n_i ),
    .wr_i      ( reg_wr ),
    .sof_i     ( sof ),
    .rhsc_i    ( rhsc ),
    .status_o  ( int_status ),
    .enable_o  ( int_enable ),
    .intr_o    ( intr_o )
  );

  // Read data and bus response
  new_usb_ohci_rsp_mux #(
    .NumPorts ( NumPorts )
  ) i_rsp_mux (
    .soc_clk_i      ( soc_clk_i ),
    .arst_n_i       ( arst_n_i ),
    .rd_i           ( reg_rd ),
    .control_i      ( control ),
    .fm_interval_i  ( fm_interval ),
    .fm_remaining_i ( fm_remaining ),
    .fm_number_i    ( fm_number ),
    .status_i       ( int_status ),
    .enable_i       ( int_enable ),
    .port_i         ( port_words ),
    .rsp_o          ( ctrl_rsp_o )
  );

endmodule

/* design/new_usb_ohci_frame_timer.sv */
module new_usb_ohci_frame_timer import new_usb_ohci_pkg::*; (
  input  logic        soc_clk_i,
  input  logic        arst_n_i,
  input  reg_wr_t     wr_i,
  output hcfs_e       hcfs_o,
  output logic [31:0] control_o,
  output logic [31:0] fm_interval_o,
  output logic [31:0] fm_remaining_o,
  output logic [31:0] fm_number_o,
  output logic        sof_o
);

  logic [31:0] control_q;
  logic [13:0] fi_q;         // Frame interval
  logic [13:0] remaining_q;
  logic [15:0] number_q;
  logic        running_q;    // Countdown loaded since entering OPERATIONAL
  logic        sof_q;
  logic        operational;

  assign hcfs_o      = hcfs_e'(control_q[7:6]);
  assign operational = (hcfs_o == OPERATIONAL);

  // Software side of HcControl and HcFmInterval
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      control_q <= '0;               // HCFS = RESET
      fi_q      <= FmIntervalReset;
    end else if (wr_i.valid) begin
      if (wr_i.id == CONTROL)     control_q <= wr_i.data & ControlWrMask;
      if (wr_i.id == FM_INTERVAL) fi_q      <= wr_i.data[13:0]; // Used at next reload
    end
  end

  // Frame countdown, FI+1 cycles per frame
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      remaining_q <= '0;
      number_q    <= '0;
      running_q   <= 1'b0;
      sof_q       <= 1'b0;
    end else begin
      sof_q <= 1'b0;
      if (!operational) begin
        remaining_q <= '0;           // Parked outside OPERATIONAL
        running_q   <= 1'b0;
      end else if (!running_q) begin
        remaining_q <= fi_q;         // First cycle in OPERATIONAL
        running_q   <= 1'b1;
      end else if (remaining_q == '0) begin
        remaining_q <= fi_q;         // Frame boundary
        number_q    <= number_q + 16'd1;
        sof_q       <= 1'b1;
      end else begin
        remaining_q <= remaining_q - 14'd1;
      end
    end
  end

  assign control_o      = control_q;
  assign fm_interval_o  = {18'd0, fi_q};
  assign fm_remaining_o = {18'd0, remaining_q};
  assign fm_number_o    = {16'd0, number_q};
  assign sof_o          = sof_q;

endmodule

/* design/new_usb_ohci_intr.sv */
module new_usb_ohci_intr import new_usb_ohci_pkg::*; (
  input  logic        soc_clk_i,
  input  logic        arst_n_i,
  input  reg_wr_t     wr_i,
  input  logic        sof_i,
  input  logic        rhsc_i,
  output logic [31:0] status_o,
  output logic [31:0] enable_o,
  output logic        intr_o
);

  // Implemented sources, MIE only exists on the enable side
  localparam logic [31:0] StatusMask = (32'd1 << IntSf) | (32'd1 << IntRhsc);
  localparam logic [31:0] EnableMask = StatusMask | (32'd1 << IntMie);

  logic [31:0] evt;
  logic [31:0] w1c;
  logic [31:0] en_set;
  logic [31:0] en_clr;
  logic [31:0] status_q;
  logic [31:0] enable_q;

  always_comb begin
    evt          = '0;
    evt[IntSf]   = sof_i;
    evt[IntRhsc] = rhsc_i;
  end

  assign w1c    = (wr_i.valid && wr_i.id == INT_STATUS)  ? (wr_i.data & StatusMask) : '0;
  assign en_set = (wr_i.valid && wr_i.id == INT_ENABLE)  ? (wr_i.data & EnableMask) : '0;
  assign en_clr = (wr_i.valid && wr_i.id == INT_DISABLE) ? (wr_i.data & EnableMask) : '0;

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q <= '0;
      enable_q <= '0;
    end else begin
      status_q <= evt | (status_q & ~w1c);     // Event wins over clear
      enable_q <= (enable_q | en_set) & ~en_clr;
    end
  end

  // Master enable gates every source
  assign intr_o   = enable_q[IntMie] & (|(status_q & enable_q & StatusMask));
  assign status_o = status_q;
  assign enable_o = enable_q;

endmodule

/* design/new_usb_ohci_pkg.sv */
package new_usb_ohci_pkg;

  // Root-hub ports unless the top level says otherwise
  localparam int unsigned NumPhyPorts = 2;

  // HcControl.HCFS encoding
  typedef enum logic [1:0] {
    RESET       = 2'b00,
    RESUME      = 2'b01,
    OPERATIONAL = 2'b10,
    SUSPEND     = 2'b11
  } hcfs_e;

  // Register selected by one bus access
  typedef enum logic [3:0] {
    REVISION,
    CONTROL,
    INT_STATUS,
    INT_ENABLE,
    INT_DISABLE,
    FM_INTERVAL,
    FM_REMAINING,
    FM_NUMBER,
    RH_DESC_A,
    RH_PORT,
    NONE            // Unmapped address
  } reg_id_e;

  // Operational register offsets
  localparam logic [7:0] OffRevision    = 8'h00;
  localparam logic [7:0] OffControl     = 8'h04;
  localparam logic [7:0] OffIntStatus   = 8'h0C;
  localparam logic [7:0] OffIntEnable   = 8'h10;
  localparam logic [7:0] OffIntDisable  = 8'h14;
  localparam logic [7:0] OffFmInterval  = 8'h34;
  localparam logic [7:0] OffFmRemaining = 8'h38;
  localparam logic [7:0] OffFmNumber    = 8'h3C;
  localparam logic [7:0] OffRhDescA     = 8'h48;
  localparam logic [7:0] OffRhPort0     = 8'h54; // Port n sits at +4n

  localparam logic [31:0] RevisionValue   = 32'h0000_0010; // OHCI 1.0
  localparam logic [31:0] ControlWrMask   = 32'h0000_00FF; // CBSR, PLE, IE, CLE, BLE, HCFS
  localparam logic [13:0] FmIntervalReset = 14'h2EDF;      // 12000 bit times minus one

  // Interrupt bit positions
  localparam int unsigned IntSf   = 2;
  localparam int unsigned IntRhsc = 6;
  localparam int unsigned IntMie  = 31;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Decoded write command
  typedef struct packed {
    logic        valid;
    reg_id_e     id;
    logic [3:0]  port;
    logic [31:0] data;
  } reg_wr_t;

  // Decoded read selection
  typedef struct packed {
    logic       valid;
    reg_id_e    id;
    logic [3:0] port;
    logic       error;
  } reg_rd_t;

  // HcRhPortStatus as read back
  typedef struct packed {
    logic [13:0] rsvd_hi;
    logic        pesc;  // Port enable status change
    logic        csc;   // Connect status change
    logic [13:0] rsvd_lo;
    logic        pes;   // Port enabled
    logic        ccs;   // Device connected
  } rh_port_status_t;

  // Same word as written by software
  typedef struct packed {
    logic [13:0] rsvd_hi;
    logic        clr_pesc;
    logic        clr_csc;
    logic [13:0] rsvd_lo;
    logic        set_port_enable;
    logic        clr_port_enable;
  } rh_port_cmd_t;

  typedef union packed {
    rh_port_status_t status;
    rh_port_cmd_t    cmd;
  } rh_port_word_u;

endpackage

/* design/new_usb_ohci_reg_decode.sv */
module new_usb_ohci_reg_decode import new_usb_ohci_pkg::*; #(
  parameter int unsigned NumPorts = NumPhyPorts
) (
  input  reg_req_t req_i,
  output reg_wr_t  wr_o,
  output reg_rd_t  rd_o
);

  logic [7:0] port_off;  // Offset into the port window
  logic [5:0] port_idx;
  logic       port_hit;
  reg_id_e    id;
  logic       writable;

  assign port_off = req_i.addr - OffRhPort0;
  assign port_idx = port_off[7:2];

  // Aligned, inside the window and below the implemented port count
  assign port_hit = (req_i.addr >= OffRhPort0) &&
                    (req_i.addr[1:0] == 2'b00) &&
                    (32'(port_idx) < NumPorts);

  always_comb begin
    case (req_i.addr)
      OffRevision:    id = REVISION;
      OffControl:     id = CONTROL;
      OffIntStatus:   id = INT_STATUS;
      OffIntEnable:   id = INT_ENABLE;
      OffIntDisable:  id = INT_DISABLE;
      OffFmInterval:  id = FM_INTERVAL;
      OffFmRemaining: id = FM_REMAINING;
      OffFmNumber:    id = FM_NUMBER;
      OffRhDescA:     id = RH_DESC_A;
      default:        id = port_hit ? RH_PORT : NONE; // HcCommandStatus falls here too
    endcase
  end

  // Read-only words drop their writes
  always_comb begin
    case (id)
      CONTROL,
      INT_STATUS,
      INT_ENABLE,
      INT_DISABLE,
      FM_INTERVAL,
      RH_PORT:  writable = 1'b1;
      default:  writable = 1'b0;
    endcase
  end

  // Write command, acted on at the strobe edge
  assign wr_o.valid = req_i.valid & req_i.write & writable;
  assign wr_o.id    = id;
  assign wr_o.port  = port_hit ? port_idx[3:0] : 4'd0;
  assign wr_o.data  = req_i.wdata;

  // Every strobe gets a response, writes included
  assign rd_o.valid = req_i.valid;
  assign rd_o.id    = id;
  assign rd_o.port  = port_hit ? port_idx[3:0] : 4'd0;
  assign rd_o.error = (id == NONE);

endmodule

/* design/new_usb_ohci_root_hub.sv */
module new_usb_ohci_root_hub import new_usb_ohci_pkg::*; #(
  parameter int unsigned NumPorts       = NumPhyPorts,
  parameter int unsigned DebounceCycles = 8
) (
  input  logic                         soc_clk_i,
  input  logic                         arst_n_i,
  input  reg_wr_t                      wr_i,
  input  logic          [NumPorts-1:0] phy_dp_i,
  input  logic          [NumPorts-1:0] phy_dm_i,
  output rh_port_word_u [NumPorts-1:0] port_o,
  output logic                         rhsc_o
);

  localparam int unsigned CntW = $clog2(DebounceCycles + 1);

  rh_port_word_u                     cmd_word;  // Write data in its command view
  logic [NumPorts-1:0]               present;
  logic [NumPorts-1:0]               wr_hit;
  logic [NumPorts-1:0]               flip;      // Debounced connect toggles
  logic [NumPorts-1:0]               set_pe;
  logic [NumPorts-1:0]               clr_pe;
  logic [NumPorts-1:0]               clr_csc;
  logic [NumPorts-1:0]               clr_pesc;
  logic [NumPorts-1:0]               ccs_q, ccs_d;
  logic [NumPorts-1:0]               pes_q, pes_d;
  logic [NumPorts-1:0]               csc_q, csc_d;
  logic [NumPorts-1:0]               pesc_q, pesc_d;
  logic [NumPorts-1:0][CntW-1:0]     cnt_q, cnt_d;
  logic                              rhsc_q;

  assign cmd_word = wr_i.data;
  assign present  = phy_dp_i ^ phy_dm_i;  // J or K, SE0 reads as empty

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      wr_hit[p] = wr_i.valid && (wr_i.id == RH_PORT) && (wr_i.port == 4'(p));

      // Line must disagree with CCS for DebounceCycles cycles in a row
      flip[p]  = 1'b0;
      cnt_d[p] = '0;
      if (present[p] != ccs_q[p]) begin
        if (cnt_q[p] == CntW'(DebounceCycles - 1)) begin
          flip[p] = 1'b1;
        end else begin
          cnt_d[p] = cnt_q[p] + CntW'(1);
        end
      end
      ccs_d[p] = ccs_q[p] ^ flip[p];

      set_pe[p]   = wr_hit[p] & cmd_word.cmd.set_port_enable;
      clr_pe[p]   = wr_hit[p] & cmd_word.cmd.clr_port_enable;
      clr_csc[p]  = wr_hit[p] & cmd_word.cmd.clr_csc;
      clr_pesc[p] = wr_hit[p] & cmd_word.cmd.clr_pesc;

      // Enable only takes on a connected port, disconnect drops it
      pes_d[p] = (pes_q[p] | (set_pe[p] & ccs_q[p])) &
                 ~clr_pe[p] & ~(flip[p] & ccs_q[p]);

      // Change bits, set beats write-one-to-clear
      csc_d[p]  = flip[p] | (set_pe[p] & ~ccs_q[p]) | (csc_q[p] & ~clr_csc[p]);
      pesc_d[p] = (flip[p] & ccs_q[p] & pes_q[p]) | (pesc_q[p] & ~clr_pesc[p]);
    end
  end

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ccs_q  <= '0;
      pes_q  <= '0;
      csc_q  <= '0;
      pesc_q <= '0;
      cnt_q  <= '0;
      rhsc_q <= 1'b0;
    end else begin
      ccs_q  <= ccs_d;
      pes_q  <= pes_d;
      csc_q  <= csc_d;
      pesc_q <= pesc_d;
      cnt_q  <= cnt_d;
      rhsc_q <= |((csc_d & ~csc_q) | (pesc_d & ~pesc_q)); // Any change bit rising
    end
  end

  // Status view for reads
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      port_o[p]             = '0;
      port_o[p].status.ccs  = ccs_q[p];
      port_o[p].status.pes  = pes_q[p];
      port_o[p].status.csc  = csc_q[p];
      port_o[p].status.pesc = pesc_q[p];
    end
  end

  assign rhsc_o = rhsc_q;

endmodule

/* design/new_usb_ohci_rsp_mux.sv */
module new_usb_ohci_rsp_mux import new_usb_ohci_pkg::*; #(
  parameter int unsigned NumPorts = NumPhyPorts
) (
  input  logic                         soc_clk_i,
  input  logic                         arst_n_i,
  input  reg_rd_t                      rd_i,
  input  logic          [31:0]         control_i,
  input  logic          [31:0]         fm_interval_i,
  input  logic          [31:0]         fm_remaining_i,
  input  logic          [31:0]         fm_number_i,
  input  logic          [31:0]         status_i,
  input  logic          [31:0]         enable_i,
  input  rh_port_word_u [NumPorts-1:0] port_i,
  output reg_rsp_t                     rsp_o
);

  // NOCP and NPS set since power switching and overcurrent are absent
  localparam logic [31:0] RhDescA = 32'h0000_1200 | 32'(NumPorts);

  logic [31:0] port_word;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        ready_q;
  logic        error_q;

  always_comb begin
    port_word = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (rd_i.port == 4'(p)) port_word = port_i[p].status;
    end
  end

  always_comb begin
    case (rd_i.id)
      REVISION:     rdata_d = RevisionValue;
      CONTROL:      rdata_d = control_i;
      INT_STATUS:   rdata_d = status_i;
      INT_ENABLE,
      INT_DISABLE:  rdata_d = enable_i;   // Both views of one register
      FM_INTERVAL:  rdata_d = fm_interval_i;
      FM_REMAINING: rdata_d = fm_remaining_i;
      FM_NUMBER:    rdata_d = fm_number_i;
      RH_DESC_A:    rdata_d = RhDescA;
      RH_PORT:      rdata_d = port_word;
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= rd_i.valid;               // Exactly one cycle after the strobe
      error_q <= rd_i.valid & rd_i.error;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (rd_i.valid) rdata_q <= rdata_d;    // Value from before the write edge
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.error = error_q;
  assign rsp_o.rdata = rdata_q;

endmodule

/* new_usb_ohci.f */
design/new_usb_ohci_pkg.sv
design/new_usb_ohci_reg_decode.sv
design/new_usb_ohci_frame_timer.sv
design/new_usb_ohci_root_hub.sv
design/new_usb_ohci_intr.sv
design/new_usb_ohci_rsp_mux.sv
design/new_usb_ohci.sv
test/tb_new_usb_ohci.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_new_usb_ohci -f new_usb_ohci.f

out=$(./obj_dir/Vtb_new_usb_ohci) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

/* test/tb_new_usb_ohci.sv */
module tb_new_usb_ohci import new_usb_ohci_pkg::*; ();

  localparam logic [31:0] SfBit    = 32'h0000_0004;
  localparam logic [31:0] RhscBit  = 32'h0000_0040;
  localparam logic [31:0] MieBit   = 32'h8000_0000;
  localparam logic [31:0] EnMask   = SfBit | RhscBit | MieBit;
  localparam logic [31:0] PortBits = 32'h0003_0003; // PESC, CSC, PES and CCS

  logic        clk;
  logic        arst_n;
  reg_req_t    req;
  reg_rsp_t    rsp;
  logic        intr;
  logic [1:0]  phy_dp;
  logic [1:0]  phy_dm;

  integer      seed;
  logic [31:0] rnd;
  logic [31:0] data;
  logic [31:0] rdata;
  logic [31:0] prev;
  logic [7:0]  addr;
  logic        err;
  int          p;
  int          q;

  // Register model
  logic [31:0] m_control;
  logic [31:0] m_fi;
  logic [31:0] m_enable;
  logic [31:0] m_port [2];

  new_usb_ohci #(
    .NumPorts       ( 2 ),
    .DebounceCycles ( 4 )
  ) new_usb_ohci_i (
    .soc_clk_i  ( clk ),
    .arst_n_i   ( arst_n ),
    .ctrl_req_i ( req ),
    .ctrl_rsp_o ( rsp ),
    .intr_o     ( intr ),
    .phy_dp_i   ( phy_dp ),
    .phy_dm_i   ( phy_dm )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
      stop_run();
    end
  endtask

  // One strobe, then wait for the response pulse
  task automatic bus_access(input logic wr, input logic [7:0] a, input logic [31:0] wd,
                            output logic [31:0] rd, output logic e);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    #2;
    req.valid = 1'b1;
    req.write = wr;
    req.addr  = a;
    req.wdata = wd;
    @(posedge clk);
    #2;
    req = '0;
    while (!rsp.ready && waited < 10) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!rsp.ready) begin
      $display("No response on ctrl_rsp_o within 10 cycles of address 0x%02h", a);
      stop_run();
    end
    rd = rsp.rdata;
    e  = rsp.error;
  endtask

  task automatic read_reg(input logic [7:0] a, output logic [31:0] rd);
    logic e;
    bus_access(1'b0, a, 32'h0, rd, e);
    check_eq("ctrl_rsp_o.error", 32'd0, 32'(e));
  endtask

  task automatic write_reg(input logic [7:0] a, input logic [31:0] wd);
    logic [31:0] rd;
    logic        e;
    bus_access(1'b1, a, wd, rd, e);
    check_eq("ctrl_rsp_o.error", 32'd0, 32'(e));
  endtask

  task automatic expect_read(input string name, input logic [7:0] a, input logic [31:0] exp);
    logic [31:0] rd;
    read_reg(a, rd);
    check_eq(name, exp, rd);
  endtask

  function automatic void update_model(input logic [7:0] a, input logic [31:0] wd);
    case (a)
      OffControl:    m_control = wd;
      OffFmInterval: m_fi      = wd & 32'h0000_3FFF; // FI field only
      OffIntEnable:  m_enable  = m_enable | (wd & EnMask);
      OffIntDisable: m_enable  = m_enable & ~(wd & EnMask);
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] a);
    case (a)
      OffRevision:   model_read = 32'h0000_0010;
      OffControl:    model_read = m_control;
      OffIntEnable,
      OffIntDisable: model_read = m_enable;     // Disable reads back the enable word
      OffFmInterval: model_read = m_fi;
      default:       model_read = 32'h0;
    endcase
  endfunction

  task automatic write_tracked(input logic [7:0] a, input logic [31:0] wd);
    write_reg(a, wd);
    update_model(a, wd);
  endtask

  // Write strobe followed directly by a read strobe of the same word
  task automatic write_then_read(input logic [7:0] a, input logic [31:0] wd,
                                 output logic [31:0] rd);
    @(posedge clk);
    #2;
    req.valid = 1'b1;
    req.write = 1'b1;
    req.addr  = a;
    req.wdata = wd;
    @(posedge clk);
    #2;
    req.write = 1'b0;
    req.wdata = '0;
    check_eq("ctrl_rsp_o.ready", 32'd1, 32'(rsp.ready)); // Write response
    check_eq("ctrl_rsp_o.error", 32'd0, 32'(rsp.error));
    @(posedge clk);
    #2;
    req = '0;
    check_eq("ctrl_rsp_o.ready", 32'd1, 32'(rsp.ready)); // Read response
    check_eq("ctrl_rsp_o.error", 32'd0, 32'(rsp.error));
    rd = rsp.rdata;
  endtask

  task automatic wait_intr(input logic exp);
    int unsigned waited;
    waited = 0;
    while (intr !== exp && waited < 200) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (intr !== exp) begin
      $display("intr_o did not reach %0d within 200 cycles", exp);
      stop_run();
    end
  endtask

  function automatic logic [7:0] port_addr(input int port);
    return OffRhPort0 + 8'(4 * port);
  endfunction

  // Poll CCS until the debounced connect matches
  task automatic wait_connect(input int port, input logic want);
    logic [31:0] word;
    int unsigned tries;
    tries = 0;
    read_reg(port_addr(port), word);
    while (word[0] !== want && tries < 20) begin
      read_reg(port_addr(port), word);
      tries++;
    end
    if (word[0] !== want) begin
      $display("Port %0d connect status did not settle to %0d within 20 reads", port, want);
      stop_run();
    end
  endtask

  task automatic check_port(input int port);
    logic [31:0] word;
    read_reg(port_addr(port), word);
    check_eq($sformatf("HcRhPortStatus[%0d]", port), m_port[port], word & PortBits);
  endtask

  initial begin
    seed      = 32'hc6e7;
    arst_n    = 1'b0;
    req       = '0;
    phy_dp    = '0;
    phy_dm    = '0;
    m_control = '0;
    m_fi      = 32'h0000_2EDF;
    m_enable  = '0;
    m_port[0] = '0;
    m_port[1] = '0;
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // Reset values and decode errors
    expect_read("HcRevision", OffRevision, 32'h0000_0010);
    expect_read("HcControl", OffControl, 32'h0);
    expect_read("HcFmInterval", OffFmInterval, 32'h0000_2EDF);
    read_reg(OffRhDescA, rdata);
    check_eq("HcRhDescriptorA.NDP", 32'd2, rdata & 32'hFF);
    check_eq("intr_o", 32'd0, 32'(intr));
    bus_access(1'b0, 8'h20, 32'h0, rdata, err);
    check_eq("ctrl_rsp_o.error", 32'd1, 32'(err));
    bus_access(1'b0, port_addr(2), 32'h0, rdata, err); // Third port is not there
    check_eq("ctrl_rsp_o.error", 32'd1, 32'(err));
    check_port(0);
    check_port(1);

    // Random register traffic against the model
    repeat (60) begin
      rnd  = $random(seed);
      data = $random(seed);
      case (rnd[2:0])
        3'd0: write_tracked(OffControl, {24'd0, data[7:0]});
        3'd1: write_tracked(OffFmInterval, data);
        3'd2: write_tracked(OffIntEnable, data);
        3'd3: write_tracked(OffIntDisable, data);
        3'd4: begin
          addr = rnd[3] ? OffControl : OffFmInterval;
          data = rnd[3] ? {24'd0, data[7:0]} : data;
          write_then_read(addr, data, rdata);
          update_model(addr, data);
          check_eq("ctrl_rsp_o.rdata", model_read(addr), rdata);
        end
        default: begin
          case (rnd[5:3])
            3'd0:    addr = OffRevision;
            3'd1:    addr = OffControl;
            3'd2:    addr = OffIntEnable;
            3'd3:    addr = OffIntDisable;
            default: addr = OffFmInterval;
          endcase
          expect_read("ctrl_rsp_o.rdata", addr, model_read(addr));
        end
      endcase
    end
    write_tracked(OffControl, 32'h0);            // Back to RESET, no more frames
    write_tracked(OffIntDisable, 32'hFFFF_FFFF);
    write_reg(OffIntStatus, 32'hFFFF_FFFF);
    expect_read("HcInterruptStatus", OffIntStatus, 32'h0);

    // Frame timer with a short random interval
    rnd = $random(seed);
    write_tracked(OffFmInterval, 32'd20 + {27'd0, rnd[4:0]});
    write_tracked(OffControl, 32'h80);           // HCFS = OPERATIONAL
    prev = '0;
    repeat (40) begin
      read_reg(OffFmRemaining, rdata);
      if (rdata > m_fi) begin
        $display("FAILED HcFmRemaining 0x%0h is above the frame interval 0x%0h", rdata, m_fi);
        stop_run();
      end
      read_reg(OffFmNumber, rdata);
      if (rdata < prev) begin
        $display("FAILED HcFmNumber went backwards from 0x%0h to 0x%0h", prev, rdata);
        stop_run();
      end
      prev = rdata;
    end
    read_reg(OffFmNumber, prev);
    repeat (3 * (m_fi + 1)) @(posedge clk);
    #2;
    read_reg(OffFmNumber, rdata);
    if (rdata < prev + 32'd2) begin
      $display("FAILED HcFmNumber grew from 0x%0h only to 0x%0h over three frames", prev, rdata);
      stop_run();
    end
    read_reg(OffIntStatus, rdata);
    check_eq("HcInterruptStatus.SF", SfBit, rdata & SfBit);

    // Interrupt output
    write_tracked(OffIntEnable, SfBit | MieBit);
    wait_intr(1'b1);
    write_tracked(OffControl, 32'h0);            // Stop frames so SF stays clear
    write_reg(OffIntStatus, SfBit);
    wait_intr(1'b0);
    expect_read("HcInterruptStatus", OffIntStatus, 32'h0);
    write_tracked(OffControl, 32'h80);
    wait_intr(1'b1);                             // Next SOF sets SF again
    write_tracked(OffIntDisable, MieBit);
    wait_intr(1'b0);
    write_tracked(OffIntEnable, MieBit);
    wait_intr(1'b1);
    write_tracked(OffIntDisable, SfBit);
    wait_intr(1'b0);
    write_tracked(OffControl, 32'h0);
    write_reg(OffIntStatus, 32'hFFFF_FFFF);
    expect_read("HcInterruptEnable", OffIntEnable, m_enable);

    // Connect and disconnect on a random port
    rnd = $random(seed);
    p   = int'(rnd[0]);
    q   = 1 - p;
    phy_dp[p] = 1'b1;                            // J state
    wait_connect(p, 1'b1);
    m_port[p] = 32'h0001_0001;
    check_port(p);
    check_port(q);
    read_reg(OffIntStatus, rdata);
    check_eq("HcInterruptStatus.RHSC", RhscBit, rdata & RhscBit);
    write_reg(port_addr(p), 32'h0001_0000);      // Clear CSC
    m_port[p] = 32'h0000_0001;
    check_port(p);
    phy_dp[p] = 1'b0;                            // SE0
    wait_connect(p, 1'b0);
    m_port[p] = 32'h0001_0000;
    check_port(p);
    write_reg(port_addr(p), 32'h0001_0000);
    m_port[p] = 32'h0;
    check_port(p);

    // Port enable and disable
    phy_dp[p] = 1'b1;
    wait_connect(p, 1'b1);
    write_reg(port_addr(p), 32'h0001_0000);
    m_port[p] = 32'h0000_0001;
    write_reg(port_addr(p), 32'h0000_0002);      // SetPortEnable
    m_port[p] = 32'h0000_0003;
    check_port(p);
    write_reg(port_addr(q), 32'h0000_0002);      // Nothing attached, flags CSC instead
    m_port[q] = 32'h0001_0000;
    check_port(q);
    write_reg(port_addr(p), 32'h0000_0001);      // ClearPortEnable
    m_port[p] = 32'h0000_0001;
    check_port(p);
    write_reg(port_addr(p), 32'h0000_0002);
    m_port[p] = 32'h0000_0003;
    check_port(p);
    phy_dp[p] = 1'b0;
    wait_connect(p, 1'b0);
    m_port[p] = 32'h0003_0000;                   // Disconnect drops PES and flags PESC
    check_port(p);

    $display("Test completed successfully");
    $finish;
  end

endmodule
